// ==== Makefile ====
# Verilator build and run for the FIB testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fib_table_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SIM_ARGS  = +verilator+error+limit+1000
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) include/fib_macros.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
+incdir+include
hw/ndn_pkg.sv
hw/fib_pkg.sv
hw/byte_serializer.sv
hw/fib_valid_table.sv
hw/fib_table_arbiter.sv
hw/packet_ingress.sv
hw/prefix_lookup.sv
hw/fib_table.sv
verification/fib_table_checker.sv
verification/fib_table_tb.sv

// ==== hw/byte_serializer.sv ====
// Byte serializer for any packed payload type
// Pulse load with the payload; bytes follow MSB first, one per cycle
module byte_serializer #(
    parameter type payload_t = logic [63:0]
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           load,
    input  payload_t       payload,
    output ndn_pkg::byte_t byte_out,
    output logic           busy
);

    // Byte count follows from the payload width
    localparam int NBYTES = $bits(payload_t) / 8;
    localparam int CNT_W  = $clog2(NBYTES + 1);

    payload_t         shift_q;
    logic [CNT_W-1:0] remain_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shift_q  <= '0;
            remain_q <= '0;
        end else if (load) begin
            // First byte shows on the cycle after load
            shift_q  <= payload;
            remain_q <= CNT_W'(NBYTES);
        end else if (remain_q != '0) begin
            // Zeros shift in, so the line idles at 0
            shift_q  <= shift_q << 8;
            remain_q <= remain_q - 1'b1;
        end
    end

    // Top byte is always the one on the wire
    assign byte_out = shift_q[$bits(payload_t)-1 -: 8];
    assign busy     = (remain_q != '0);

endmodule

// ==== hw/fib_pkg.sv ====
// Valid-bit table types and the prefix hash
// The lookup, the ingress learner and the reference model all hash through here
`include "fib_macros.svh"

package fib_pkg;

    // Row index, one row per prefix length
    typedef logic [`FIB_LEN_BITS-1:0] prefix_len_t;

    // Slot index within a row
    typedef logic [`FIB_HASH_BITS-1:0] hash_t;

    // Slices needed to cover the whole prefix
    localparam int HASH_SLICES = ($bits(ndn_pkg::prefix_t) + `FIB_HASH_BITS - 1) / `FIB_HASH_BITS;

    // Fold hash
    // Zero-extend the prefix, then XOR all hash-wide slices together
    function automatic hash_t prefix_hash(input ndn_pkg::prefix_t prefix);
        logic [HASH_SLICES*`FIB_HASH_BITS-1:0] ext;
        hash_t folded;
        ext = '0;
        ext[$bits(ndn_pkg::prefix_t)-1:0] = prefix;
        folded = '0;
        for (int s = 0; s < HASH_SLICES; s++) begin
            folded = folded ^ ext[s*`FIB_HASH_BITS +: `FIB_HASH_BITS];
        end
        return folded;
    endfunction

endpackage

// ==== hw/fib_table.sv ====
// FIB top level of the NDN router
// Ingress learner and lookup engine share one valid table through the arbiter
module fib_table (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx_valid,
    input  ndn_pkg::byte_t     data_spi_to_fib,
    input  logic               rejected,
    input  logic               start_send_to_pit,
    input  logic               fib_out_bit,
    input  ndn_pkg::prefix_t   pit_in_prefix,
    input  ndn_pkg::metadata_t pit_in_metadata,
    output ndn_pkg::prefix_t   pit_out_prefix,
    output ndn_pkg::metadata_t pit_out_metadata,
    output logic               prefix_ready,
    output ndn_pkg::byte_t     data_fib_to_pit,
    output logic               fib_to_spi_data_flag,
    output ndn_pkg::byte_t     data_fib_to_spi
);

    import fib_pkg::*;

    // Ingress write port
    logic        write_req;
    logic        write_grant;
    prefix_len_t write_len;
    hash_t       write_hash;

    // Lookup read port
    logic        read_req;
    logic        read_grant;
    prefix_len_t read_len;
    hash_t       read_hash;

    // Arbitrated table port
    logic        table_access;
    logic        table_write;
    prefix_len_t table_len;
    hash_t       table_hash;
    logic        hit;

    packet_ingress u_ingress (
        .clk              (clk),
        .rst              (rst),
        .rx_valid         (rx_valid),
        .data_spi_to_fib  (data_spi_to_fib),
        .rejected         (rejected),
        .start_send_to_pit(start_send_to_pit),
        .write_grant      (write_grant),
        .pit_out_prefix   (pit_out_prefix),
        .pit_out_metadata (pit_out_metadata),
        .prefix_ready     (prefix_ready),
        .data_fib_to_pit  (data_fib_to_pit),
        .write_req        (write_req),
        .write_len        (write_len),
        .write_hash       (write_hash)
    );

    prefix_lookup u_lookup (
        .clk                 (clk),
        .rst                 (rst),
        .fib_out_bit         (fib_out_bit),
        .pit_in_prefix       (pit_in_prefix),
        .pit_in_metadata     (pit_in_metadata),
        .read_grant          (read_grant),
        .hit                 (hit),
        .read_req            (read_req),
        .read_len            (read_len),
        .read_hash           (read_hash),
        .fib_to_spi_data_flag(fib_to_spi_data_flag),
        .data_fib_to_spi     (data_fib_to_spi)
    );

    fib_table_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .write_req   (write_req),
        .write_len   (write_len),
        .write_hash  (write_hash),
        .read_req    (read_req),
        .read_len    (read_len),
        .read_hash   (read_hash),
        .write_grant (write_grant),
        .read_grant  (read_grant),
        .table_access(table_access),
        .table_write (table_write),
        .table_len   (table_len),
        .table_hash  (table_hash)
    );

    fib_valid_table u_table (
        .clk         (clk),
        .rst         (rst),
        .table_access(table_access),
        .table_write (table_write),
        .table_len   (table_len),
        .table_hash  (table_hash),
        .hit         (hit)
    );

endmodule

// ==== hw/fib_table_arbiter.sv ====
// Arbiter for the single valid-table port
// Writer has fixed priority; each grant is a registered one-cycle pulse
// Table strobe, row and slot are registered with the grant
module fib_table_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 write_req,
    input  fib_pkg::prefix_len_t write_len,
    input  fib_pkg::hash_t       write_hash,
    input  logic                 read_req,
    input  fib_pkg::prefix_len_t read_len,
    input  fib_pkg::hash_t       read_hash,
    output logic                 write_grant,
    output logic                 read_grant,
    output logic                 table_access,
    output logic                 table_write,
    output fib_pkg::prefix_len_t table_len,
    output fib_pkg::hash_t       table_hash
);

    logic grant_w_next;
    logic grant_r_next;

    // Requests are still held during their grant cycle
    // so a peer that holds a grant now is not granted again
    assign grant_w_next = write_req && !write_grant;
    // Reader only wins when the writer is not about to be granted
    assign grant_r_next = read_req && !read_grant && !grant_w_next;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            write_grant  <= 1'b0;
            read_grant   <= 1'b0;
            table_access <= 1'b0;
            table_write  <= 1'b0;
        end else begin
            write_grant  <= grant_w_next;
            read_grant   <= grant_r_next;
            table_access <= grant_w_next || grant_r_next;
            table_write  <= grant_w_next;
        end
    end

    // Address of the winner, only looked at while table_access is high
    always_ff @(posedge clk) begin
        table_len  <= grant_w_next ? write_len : read_len;
        table_hash <= grant_w_next ? write_hash : read_hash;
    end

endmodule

// ==== hw/fib_valid_table.sv ====
// Valid-bit array, one row per prefix length and one bit per hash slot
// Single port driven by the arbiter; read data shows on hit a cycle later
`include "fib_macros.svh"

module fib_valid_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                table_access,
    input  logic                table_write,
    input  fib_pkg::prefix_len_t table_len,
    input  fib_pkg::hash_t      table_hash,
    output logic                hit
);

    // 64 rows of 1024 valid bits
    logic [(1 << `FIB_HASH_BITS)-1:0] valid_q [1 << `FIB_LEN_BITS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Nothing learned yet
            for (int r = 0; r < (1 << `FIB_LEN_BITS); r++) begin
                valid_q[r] <= '0;
            end
            hit <= 1'b0;
        end else if (table_access) begin
            if (table_write) begin
                // Learned prefixes are only ever set
                valid_q[table_len][table_hash] <= 1'b1;
            end else begin
                hit <= valid_q[table_len][table_hash];
            end
        end
    end

endmodule

// ==== hw/ndn_pkg.sv ====
// Packet-format types of the NDN wire protocol
// Shared by the ingress parser, the lookup engine and the testbench
`include "fib_macros.svh"

package ndn_pkg;

    // One byte of the SPI or PIT stream
    typedef logic [7:0] byte_t;

    // Metadata byte
    // Bit 6 set for interest, clear for data
    // Bits 5 to 0 carry the prefix length
    typedef logic [7:0] metadata_t;

    // Name prefix, most significant byte first on the wire
    typedef logic [8*`FIB_PREFIX_BYTES-1:0] prefix_t;

    // Data packet payload
    typedef logic [8*`FIB_DATA_BYTES-1:0] content_t;

endpackage

// ==== hw/packet_ingress.sv ====
// Receive side of the FIB
// Parses SPI packets, announces each prefix to the PIT, relays accepted data
// and learns every prefix into the valid table
`include "fib_macros.svh"

module packet_ingress (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_valid,
    input  ndn_pkg::byte_t       data_spi_to_fib,
    input  logic                 rejected,
    input  logic                 start_send_to_pit,
    input  logic                 write_grant,
    output ndn_pkg::prefix_t     pit_out_prefix,
    output ndn_pkg::metadata_t   pit_out_metadata,
    output logic                 prefix_ready,
    output ndn_pkg::byte_t       data_fib_to_pit,
    output logic                 write_req,
    output fib_pkg::prefix_len_t write_len,
    output fib_pkg::hash_t       write_hash
);

    import ndn_pkg::*;
    import fib_pkg::*;

    localparam int CNT_W = $clog2(`FIB_DATA_BYTES);

    typedef enum logic [2:0] {
        I_IDLE, I_META, I_PREFIX, I_DATA, I_RESP, I_RELAY, I_WRITE
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] byte_cnt;
    metadata_t        meta_q;
    prefix_t          prefix_sr;
    prefix_t          prefix_next;
    content_t         content_sr;
    logic             is_interest;
    logic             announce;
    logic             relay_load;
    logic             relay_busy;

    assign is_interest = meta_q[`FIB_INTEREST_BIT];
    // Prefix including the byte on the line right now
    assign prefix_next = {prefix_sr[$bits(prefix_t)-9:0], data_spi_to_fib};

    // Last byte of the packet is on the line
    assign announce = (state == I_PREFIX && byte_cnt == '0 && is_interest) ||
                      (state == I_DATA && byte_cnt == '0);

    // Rejected wins if the PIT raises both
    assign relay_load = (state == I_RESP) && !rejected && start_send_to_pit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= I_IDLE;
            byte_cnt         <= '0;
            prefix_ready     <= 1'b0;
            pit_out_prefix   <= '0;
            pit_out_metadata <= '0;
        end else begin
            prefix_ready <= announce;
            if (announce) begin
                // Held until the next packet is announced
                pit_out_prefix   <= (state == I_DATA) ? prefix_sr : prefix_next;
                pit_out_metadata <= meta_q;
            end
            case (state)
                I_IDLE: if (rx_valid) state <= I_META;
                I_META: begin
                    byte_cnt <= CNT_W'(`FIB_PREFIX_BYTES - 1);
                    state    <= I_PREFIX;
                end
                I_PREFIX: begin
                    byte_cnt <= byte_cnt - 1'b1;
                    if (byte_cnt == '0) begin
                        if (is_interest) begin
                            state <= I_WRITE;
                        end else begin
                            byte_cnt <= CNT_W'(`FIB_DATA_BYTES - 1);
                            state    <= I_DATA;
                        end
                    end
                end
                I_DATA: begin
                    byte_cnt <= byte_cnt - 1'b1;
                    if (byte_cnt == '0) state <= I_RESP;
                end
                // PIT may take any number of cycles to answer
                I_RESP: begin
                    if (rejected) state <= I_WRITE;
                    else if (start_send_to_pit) state <= I_RELAY;
                end
                I_RELAY: if (!relay_busy) state <= I_WRITE;
                I_WRITE: if (write_grant) state <= I_IDLE;
                default: state <= I_IDLE;
            endcase
        end
    end

    // Packet fields, shifted in MSB first
    always_ff @(posedge clk) begin
        case (state)
            I_META:   meta_q <= data_spi_to_fib;
            I_PREFIX: prefix_sr <= prefix_next;
            I_DATA:   content_sr <= {content_sr[$bits(content_t)-9:0], data_spi_to_fib};
            default:  ;
        endcase
    end

    byte_serializer #(
        .payload_t(content_t)
    ) u_content_out (
        .clk     (clk),
        .rst     (rst),
        .load    (relay_load),
        .payload (content_sr),
        .byte_out(data_fib_to_pit),
        .busy    (relay_busy)
    );

    // Learn the announced prefix at its own length
    assign write_req  = (state == I_WRITE);
    assign write_len  = pit_out_metadata[`FIB_LEN_BITS-1:0];
    assign write_hash = prefix_hash(pit_out_prefix);

endmodule

// ==== hw/prefix_lookup.sv ====
// Longest-prefix lookup for outgoing interests
// Start with fib_out_bit; the result frame follows the fib_to_spi_data_flag pulse
// Frame is metadata, total prefix, then the prefix as found
`include "fib_macros.svh"

module prefix_lookup (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fib_out_bit,
    input  ndn_pkg::prefix_t     pit_in_prefix,
    input  ndn_pkg::metadata_t   pit_in_metadata,
    input  logic                 read_grant,
    input  logic                 hit,
    output logic                 read_req,
    output fib_pkg::prefix_len_t read_len,
    output fib_pkg::hash_t       read_hash,
    output logic                 fib_to_spi_data_flag,
    output ndn_pkg::byte_t       data_fib_to_spi
);

    import ndn_pkg::*;
    import fib_pkg::*;

    localparam int CNT_W = $clog2(`FIB_PREFIX_BYTES);

    typedef enum logic [2:0] {
        L_IDLE, L_HASH, L_REQ, L_CHECK, L_FLAG, L_META, L_TOTAL, L_FOUND
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] byte_cnt;
    prefix_t          prefix_q;
    prefix_t          total_q;
    metadata_t        meta_q;
    prefix_len_t      len_q;
    hash_t            hash_q;
    logic             search_done;
    logic             ser_load;
    byte_t            ser_byte;
    logic             ser_busy;

    // Hit valid in L_CHECK, one cycle after the read grant
    assign search_done = hit || (len_q == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= L_IDLE;
            byte_cnt <= '0;
        end else begin
            case (state)
                L_IDLE:  if (fib_out_bit) state <= L_HASH;
                L_HASH:  state <= L_REQ;
                L_REQ:   if (read_grant) state <= L_CHECK;
                L_CHECK: state <= search_done ? L_FLAG : L_HASH;
                L_FLAG:  state <= L_META;
                L_META: begin
                    byte_cnt <= CNT_W'(`FIB_PREFIX_BYTES - 1);
                    state    <= L_TOTAL;
                end
                L_TOTAL: begin
                    byte_cnt <= byte_cnt - 1'b1;
                    if (byte_cnt == '0) state <= L_FOUND;
                end
                L_FOUND: if (!ser_busy) state <= L_IDLE;
                default: state <= L_IDLE;
            endcase
        end
    end

    // Search registers
    always_ff @(posedge clk) begin
        case (state)
            L_IDLE: begin
                if (fib_out_bit) begin
                    prefix_q <= pit_in_prefix;
                    total_q  <= pit_in_prefix;
                    meta_q   <= pit_in_metadata;
                    len_q    <= pit_in_metadata[`FIB_LEN_BITS-1:0];
                end
            end
            L_HASH: hash_q <= prefix_hash(prefix_q);
            L_CHECK: begin
                // On a miss drop bit L and try one length shorter
                if (!search_done) begin
                    prefix_q[len_q] <= 1'b0;
                    len_q           <= len_q - 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign read_req  = (state == L_REQ);
    assign read_len  = len_q;
    assign read_hash = hash_q;

    // Serializer loaded twice with total prefix then found prefix back to back
    assign ser_load = (state == L_META) || (state == L_TOTAL && byte_cnt == '0);

    byte_serializer #(
        .payload_t(prefix_t)
    ) u_prefix_out (
        .clk     (clk),
        .rst     (rst),
        .load    (ser_load),
        .payload ((state == L_META) ? total_q : prefix_q),
        .byte_out(ser_byte),
        .busy    (ser_busy)
    );

    assign fib_to_spi_data_flag = (state == L_FLAG);
    // Metadata goes out directly, prefixes through the serializer
    assign data_fib_to_spi      = (state == L_META) ? meta_q : ser_byte;

endmodule

// ==== include/fib_macros.svh ====
// Size constants for the NDN FIB packet format and valid-bit table
// Include in any package, RTL or testbench file that needs the sizes
`ifndef FIB_MACROS_SVH
`define FIB_MACROS_SVH

// Prefix bytes on the wire after the metadata byte
`define FIB_PREFIX_BYTES 8

// Content bytes that follow the prefix in a data packet
`define FIB_DATA_BYTES 32

// Hash width, which sets the slots per length row
`define FIB_HASH_BITS 10

// Prefix-length field width, which sets the number of rows
`define FIB_LEN_BITS 6

// Metadata bit that marks an interest packet
`define FIB_INTEREST_BIT 6

`endif

// ==== verification/fib_table_checker.sv ====
// Protocol assertions for the FIB top level, bound into fib_table
// Failures also count up in assert_errors for the testbench summary
module fib_table_checker (
    input logic clk,
    input logic rst,
    input logic prefix_ready,
    input logic fib_to_spi_data_flag,
    input logic write_grant,
    input logic read_grant
);

    int unsigned assert_errors = 0;

    // Announcement to the PIT lasts one cycle
    prefix_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        prefix_ready |=> !prefix_ready)
        else begin
            $error("prefix_ready stayed high for a second cycle");
            assert_errors++;
        end

    // Frame start toward SPI lasts one cycle
    spi_flag_pulse: assert property (@(posedge clk) disable iff (rst)
        fib_to_spi_data_flag |=> !fib_to_spi_data_flag)
        else begin
            $error("fib_to_spi_data_flag stayed high for a second cycle");
            assert_errors++;
        end

    // Single table port, one owner per cycle
    grant_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(write_grant && read_grant))
        else begin
            $error("write_grant and read_grant high together");
            assert_errors++;
        end

endmodule

bind fib_table fib_table_checker u_checker (
    .clk                 (clk),
    .rst                 (rst),
    .prefix_ready        (prefix_ready),
    .fib_to_spi_data_flag(fib_to_spi_data_flag),
    .write_grant         (write_grant),
    .read_grant          (read_grant)
);

// ==== verification/fib_table_tb.sv ====
// Testbench for the FIB top level
// Applies a table of interest, data and lookup operations and checks every
// announcement, relay stream and lookup frame against a model of the valid table
`include "fib_macros.svh"

module fib_table_tb;

    import ndn_pkg::*;
    import fib_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int GROUPS         = 3;
    localparam int NUM_TESTS      = 7 * GROUPS;
    localparam int LOOKUP_TIMEOUT = 400;
    localparam int IDLE_GAP       = 6;

    typedef enum logic [1:0] {
        OP_INTEREST, OP_DATA_REJECT, OP_DATA_RELAY, OP_LOOKUP
    } op_t;

    // One stimulus row
    typedef struct packed {
        op_t       op;
        metadata_t meta;
        prefix_t   prefix;
    } entry_t;

    logic      clk;
    logic      rst;
    logic      rx_valid;
    byte_t     data_spi_to_fib;
    logic      rejected;
    logic      start_send_to_pit;
    logic      fib_out_bit;
    prefix_t   pit_in_prefix;
    metadata_t pit_in_metadata;
    prefix_t   pit_out_prefix;
    metadata_t pit_out_metadata;
    logic      prefix_ready;
    byte_t     data_fib_to_pit;
    logic      fib_to_spi_data_flag;
    byte_t     data_fib_to_spi;

    entry_t tests [NUM_TESTS];
    // Learned valid bits, keyed by {length, hash}
    bit     learned [bit [`FIB_LEN_BITS+`FIB_HASH_BITS-1:0]];
    int     test_errors;
    int     total_errors;
    int     checks;

    fib_table u_fib_table (
        .clk(clk), .rst(rst),
        .rx_valid(rx_valid), .data_spi_to_fib(data_spi_to_fib),
        .rejected(rejected), .start_send_to_pit(start_send_to_pit),
        .fib_out_bit(fib_out_bit),
        .pit_in_prefix(pit_in_prefix), .pit_in_metadata(pit_in_metadata),
        .pit_out_prefix(pit_out_prefix), .pit_out_metadata(pit_out_metadata),
        .prefix_ready(prefix_ready), .data_fib_to_pit(data_fib_to_pit),
        .fib_to_spi_data_flag(fib_to_spi_data_flag), .data_fib_to_spi(data_fib_to_spi)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Ones in bits len down to 0
    function automatic prefix_t low_mask(input int len);
        return (prefix_t'(1) << (len + 1)) - 1'b1;
    endfunction

    function automatic prefix_t rand_prefix();
        return {$urandom, $urandom};
    endfunction

    function automatic metadata_t make_meta(input bit interest, input int len);
        metadata_t m;
        m = '0;
        m[`FIB_INTEREST_BIT] = interest;
        m[`FIB_LEN_BITS-1:0] = prefix_len_t'(len);
        return m;
    endfunction

    // Ingress packet whose prefix has nothing above its own length
    function automatic entry_t learn_entry(input op_t op, input int len);
        entry_t e;
        e.op     = op;
        e.meta   = make_meta(op == OP_INTEREST, len);
        e.prefix = rand_prefix() & low_mask(len);
        return e;
    endfunction

    // Longer lookup that walks back down to the learned source
    function automatic entry_t widen_entry(input entry_t src);
        entry_t e;
        int     base;
        int     top;
        base     = int'(src.meta[`FIB_LEN_BITS-1:0]);
        top      = base + 1 + int'($urandom_range(9, 0));
        e.op     = OP_LOOKUP;
        e.meta   = make_meta(1'b1, top);
        e.prefix = src.prefix | (rand_prefix() & low_mask(top) & ~low_mask(base));
        return e;
    endfunction

    // Longest-prefix walk clears bit L and shortens until a hit or length 0
    function automatic prefix_t model_found(input entry_t e);
        prefix_t     p;
        prefix_len_t len;
        p   = e.prefix;
        len = e.meta[`FIB_LEN_BITS-1:0];
        while (!learned.exists({len, prefix_hash(p)}) && len != '0) begin
            p[len] = 1'b0;
            len    = len - 1'b1;
        end
        return p;
    endfunction

    function automatic string describe(input op_t op);
        case (op)
            OP_INTEREST:    return "interest";
            OP_DATA_REJECT: return "data rejected";
            OP_DATA_RELAY:  return "data relayed";
            default:        return "lookup";
        endcase
    endfunction

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        if (exp !== act) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_prefix(input string name, input prefix_t exp, input prefix_t act);
        checks++;
        if (exp !== act) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_meta(input string name, input metadata_t exp, input metadata_t act);
        checks++;
        if (exp !== act) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_missing(input string what);
        $display("t=%0t %s", $time, what);
        test_errors++;
    endtask

    task automatic build_table();
        entry_t interest_e;
        entry_t reject_e;
        entry_t relay_e;
        for (int g = 0; g < GROUPS; g++) begin
            interest_e = learn_entry(OP_INTEREST, $urandom_range(20, 5));
            reject_e   = learn_entry(OP_DATA_REJECT, $urandom_range(35, 21));
            relay_e    = learn_entry(OP_DATA_RELAY, $urandom_range(50, 36));
            tests[7*g]     = interest_e;
            tests[7*g + 1] = reject_e;
            tests[7*g + 2] = relay_e;
            tests[7*g + 3] = widen_entry(interest_e);
            tests[7*g + 4] = widen_entry(reject_e);
            tests[7*g + 5] = widen_entry(relay_e);
            // Fresh full-length prefix, normally walks all the way to length 0
            tests[7*g + 6].op     = OP_LOOKUP;
            tests[7*g + 6].meta   = make_meta(1'b1, 63);
            tests[7*g + 6].prefix = rand_prefix();
        end
    endtask

    // Start strobe, metadata, prefix, content; announcement one cycle later
    task automatic send_packet(input entry_t e, input content_t content);
        @(negedge clk);
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid        = 1'b0;
        data_spi_to_fib = e.meta;
        for (int i = `FIB_PREFIX_BYTES - 1; i >= 0; i--) begin
            @(negedge clk);
            data_spi_to_fib = e.prefix[8*i +: 8];
        end
        if (e.op != OP_INTEREST) begin
            for (int i = `FIB_DATA_BYTES - 1; i >= 0; i--) begin
                @(negedge clk);
                data_spi_to_fib = content[8*i +: 8];
            end
        end
        @(negedge clk);
        data_spi_to_fib = '0;
        if (prefix_ready !== 1'b1) begin
            report_missing("prefix_ready did not pulse one cycle after the last byte");
        end
        check_prefix("pit_out_prefix", e.prefix, pit_out_prefix);
        check_meta("pit_out_metadata", e.meta, pit_out_metadata);
    endtask

    // PIT answers after a short random wait
    // Relay shows content MSB first, a reject keeps the line at 0
    task automatic answer_pit(input bit relay, input content_t content);
        repeat ($urandom_range(3, 0)) @(negedge clk);
        if (relay) start_send_to_pit = 1'b1;
        else rejected = 1'b1;
        for (int i = `FIB_DATA_BYTES - 1; i >= 0; i--) begin
            @(negedge clk);
            start_send_to_pit = 1'b0;
            rejected          = 1'b0;
            check_byte("data_fib_to_pit", relay ? content[8*i +: 8] : 8'h00, data_fib_to_pit);
        end
    endtask

    task automatic run_lookup(input entry_t e);
        prefix_t found;
        int      waited;
        found = model_found(e);
        @(negedge clk);
        fib_out_bit     = 1'b1;
        pit_in_prefix   = e.prefix;
        pit_in_metadata = e.meta;
        @(negedge clk);
        fib_out_bit = 1'b0;
        waited      = 0;
        while (fib_to_spi_data_flag !== 1'b1 && waited < LOOKUP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (fib_to_spi_data_flag !== 1'b1) begin
            report_missing("fib_to_spi_data_flag never pulsed for the lookup");
        end else begin
            // 17 bytes follow the flag
            @(negedge clk);
            check_byte("data_fib_to_spi", e.meta, data_fib_to_spi);
            for (int i = `FIB_PREFIX_BYTES - 1; i >= 0; i--) begin
                @(negedge clk);
                check_byte("data_fib_to_spi", e.prefix[8*i +: 8], data_fib_to_spi);
            end
            for (int i = `FIB_PREFIX_BYTES - 1; i >= 0; i--) begin
                @(negedge clk);
                check_byte("data_fib_to_spi", found[8*i +: 8], data_fib_to_spi);
            end
        end
    endtask

    task automatic apply(input entry_t e);
        content_t content;
        content = '0;
        if (e.op == OP_LOOKUP) begin
            run_lookup(e);
        end else begin
            for (int w = 0; w < $bits(content_t) / 32; w++) begin
                content[32*w +: 32] = $urandom;
            end
            send_packet(e, content);
            if (e.op != OP_INTEREST) answer_pit(e.op == OP_DATA_RELAY, content);
            // Every received prefix is learned at its own length
            learned[{e.meta[`FIB_LEN_BITS-1:0], prefix_hash(e.prefix)}] = 1'b1;
        end
    endtask

    initial begin
        void'($urandom(32'h6bd8_7e9e));
        clk               = 1'b0;
        rst               = 1'b1;
        rx_valid          = 1'b0;
        data_spi_to_fib   = '0;
        rejected          = 1'b0;
        start_send_to_pit = 1'b0;
        fib_out_bit       = 1'b0;
        pit_in_prefix     = '0;
        pit_in_metadata   = '0;
        total_errors      = 0;
        checks            = 0;
        build_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            apply(tests[t]);
            total_errors += test_errors;
            if (test_errors == 0) $display("test %0d %s: ok", t, describe(tests[t].op));
            else $display("test %0d %s: %0d errors", t, describe(tests[t].op), test_errors);
            // Let the learner write land before the next row
            repeat (IDLE_GAP) @(negedge clk);
        end
        total_errors += int'(u_fib_table.u_checker.assert_errors);
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 NUM_TESTS, checks, total_errors, u_fib_table.u_checker.assert_errors);
        if (total_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Budget of 200 cycles per table row
    initial begin
        repeat (NUM_TESTS * 200) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", NUM_TESTS * 200);
        $display("TEST FAIL");
        $finish;
    end

endmodule
